//--- hw/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data path width
`define LEN_WORD 32

// physical register file has 64 entries
`define LEN_PREG_ADDR 6

// word address into data memory
`define LEN_MEM_ADDR 12

// speculation context tag
`define LEN_CONTEXT 2

// instruction fields
`define LEN_FUNC3 3
`define LEN_FUNC7 7

`endif

//--- hw/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

    typedef enum logic [2:0] {
        ALU,
        SUBST,
        JUMP,
        BRANCH,
        MEM,
        IO
    } exec_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_ACCESS,
        MEM_WAIT
    } mem_state_e;

    typedef enum logic [1:0] {
        IO_IDLE,
        IO_REQ,
        IO_WAIT,
        IO_FIN
    } io_state_e;

    // io_type: 1 for store / uart write, 0 for load / uart read
    typedef struct packed {
        exec_type_e                exec_type;
        logic                      io_type;
        logic [`LEN_FUNC3-1:0]     func3;
        logic [`LEN_FUNC7-1:0]     func7;
        logic [`LEN_PREG_ADDR-1:0] pa_rd;
        logic [`LEN_WORD-1:0]      d_rs1;
        logic [`LEN_WORD-1:0]      d_rs2;
        logic [`LEN_CONTEXT-1:0]   ctx;
    } exec_info_t;

    typedef struct packed {
        logic                      valid;
        logic [`LEN_PREG_ADDR-1:0] pa_rd;
        logic [`LEN_WORD-1:0]      data;
    } write_d_r_t;

    // hazard means taken, i.e. the not-taken guess was wrong
    typedef struct packed {
        logic                    is_jump;
        logic [`LEN_WORD-1:0]    next_pc;
        logic                    is_branch;
        logic [`LEN_CONTEXT-1:0] ctx;
        logic                    hazard;
    } j_b_info_t;

    typedef struct packed {
        logic                     en;
        logic [`LEN_MEM_ADDR-1:0] a;
        logic [`LEN_WORD-1:0]     sd;
        logic [3:0]               write;
    } mem_req_t;

    typedef struct packed {
        logic                 order;
        logic                 write_flag;
        logic [1:0]           size;
        logic [`LEN_WORD-1:0] o_data;
    } to_uart_t;

    typedef struct packed {
        logic                 accepted;
        logic                 done;
        logic [`LEN_WORD-1:0] i_data;
    } from_uart_t;

endpackage

//--- hw/alu.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module alu import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  order,
    input  logic [`LEN_FUNC3-1:0] func3,
    input  logic [`LEN_FUNC7-1:0] func7,
    input  logic                  subst,
    input  logic [`LEN_WORD-1:0]  d_rs1,
    input  logic [`LEN_WORD-1:0]  d_rs2,
    output logic                  accepted,
    output logic                  done,
    output logic [`LEN_WORD-1:0]  rd
);

    localparam int SHW = $clog2(`LEN_WORD);

    alu_op_e              op;
    logic [SHW-1:0]       shamt;
    logic [`LEN_WORD-1:0] result;

    // func7 bit 5 picks sub and sra
    always_comb begin
        case (func3)
            3'b000:  op = func7[5] ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = func7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    assign shamt = d_rs2[SHW-1:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = d_rs1 + d_rs2;
            ALU_SUB:  result = d_rs1 - d_rs2;
            ALU_SLL:  result = d_rs1 << shamt;
            ALU_SLT:  result = {{(`LEN_WORD-1){1'b0}}, $signed(d_rs1) < $signed(d_rs2)};
            ALU_SLTU: result = {{(`LEN_WORD-1){1'b0}}, d_rs1 < d_rs2};
            ALU_XOR:  result = d_rs1 ^ d_rs2;
            ALU_SRL:  result = d_rs1 >> shamt;
            ALU_SRA:  result = $signed(d_rs1) >>> shamt;
            ALU_OR:   result = d_rs1 | d_rs2;
            default:  result = d_rs1 & d_rs2;
        endcase
    end

    assign accepted = order;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= accepted;
        end
    end

    // register moves just forward rs1
    always_ff @(posedge clk) begin
        if (accepted) begin
            rd <= subst ? d_rs1 : result;
        end
    end

endmodule

//--- hw/branch_unit.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module branch_unit (
    input  logic                  order,
    input  logic                  is_jump,
    input  logic [`LEN_FUNC3-1:0] func3,
    input  logic [`LEN_WORD-1:0]  d_rs1,
    input  logic [`LEN_WORD-1:0]  d_rs2,
    output logic                  accepted,
    output logic                  done,
    output logic                  taken,
    output logic [`LEN_WORD-1:0]  next_pc,
    output logic [`LEN_WORD-1:0]  rd
);

    logic cond;

    always_comb begin
        case (func3)
            3'b000:  cond = (d_rs1 == d_rs2);
            3'b001:  cond = (d_rs1 != d_rs2);
            3'b100:  cond = ($signed(d_rs1) < $signed(d_rs2));
            3'b101:  cond = ($signed(d_rs1) >= $signed(d_rs2));
            3'b110:  cond = (d_rs1 < d_rs2);
            3'b111:  cond = (d_rs1 >= d_rs2);
            default: cond = 1'b0;
        endcase
    end

    // single cycle unit
    assign accepted = order;
    assign done     = order;

    assign taken = ~is_jump & cond;

    // jump target and return address arrive precomputed
    assign next_pc = d_rs1;
    assign rd      = is_jump ? d_rs2 : '0;

endmodule

//--- hw/memory_unit.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module memory_unit import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  order,
    input  logic                  io_type,
    input  logic [`LEN_FUNC3-1:0] func3,
    input  logic [`LEN_WORD-1:0]  d_rs1,
    input  logic [`LEN_WORD-1:0]  d_rs2,
    input  logic [`LEN_WORD-1:0]  mem_ld,
    output logic                  accepted,
    output logic                  done,
    output logic [`LEN_WORD-1:0]  rd,
    output mem_req_t              mem_req
);

    mem_state_e state;

    logic [1:0]               off, off_r;
    logic [3:0]               be, be_r;
    logic [`LEN_WORD-1:0]     sd_lane, sd_r, ld_lane;
    logic [`LEN_MEM_ADDR-1:0] addr_r;
    logic [`LEN_FUNC3-1:0]    func3_r;
    logic                     store_r;

    assign accepted = order & (state == MEM_IDLE);

    // byte lanes for the store
    always_comb begin
        off = d_rs1[1:0];
        case (func3[1:0])
            2'b00:   be = 4'b0001 << off;
            2'b01:   be = 4'b0011 << off;
            default: be = 4'b1111;
        endcase
        sd_lane = d_rs2 << {off, 3'b000};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE:   if (accepted) state <= MEM_ACCESS;
                MEM_ACCESS: state <= store_r ? MEM_IDLE : MEM_WAIT;
                default:    state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            addr_r  <= d_rs1[`LEN_MEM_ADDR+1:2];
            off_r   <= off;
            be_r    <= be;
            sd_r    <= sd_lane;
            func3_r <= func3;
            store_r <= io_type;
        end
    end

    assign mem_req.en    = (state == MEM_ACCESS);
    assign mem_req.a     = addr_r;
    assign mem_req.sd    = sd_r;
    assign mem_req.write = (state == MEM_ACCESS && store_r) ? be_r : 4'b0000;

    // store ends at the access, load once the read word is back
    assign done = (state == MEM_ACCESS && store_r) || (state == MEM_WAIT);

    assign ld_lane = mem_ld >> {off_r, 3'b000};

    always_comb begin
        case (func3_r)
            3'b000:  rd = {{(`LEN_WORD-8){ld_lane[7]}}, ld_lane[7:0]};
            3'b001:  rd = {{(`LEN_WORD-16){ld_lane[15]}}, ld_lane[15:0]};
            3'b100:  rd = {{(`LEN_WORD-8){1'b0}}, ld_lane[7:0]};
            3'b101:  rd = {{(`LEN_WORD-16){1'b0}}, ld_lane[15:0]};
            default: rd = ld_lane;
        endcase
    end

endmodule

//--- hw/io_unit.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module io_unit import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  order,
    input  logic                  io_type,
    input  logic [`LEN_FUNC3-1:0] func3,
    input  logic [`LEN_WORD-1:0]  d_rs1,
    input  from_uart_t            from_uart,
    output logic                  accepted,
    output logic                  done,
    output logic [`LEN_WORD-1:0]  rd,
    output to_uart_t              to_uart
);

    io_state_e state;

    logic                 write_r;
    logic [1:0]           size_r;
    logic [`LEN_WORD-1:0] o_data_r;

    assign accepted = order & (state == IO_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IO_IDLE;
        end else begin
            case (state)
                IO_IDLE: if (accepted) state <= IO_REQ;
                // uart may accept and finish in the same cycle
                IO_REQ: begin
                    if (from_uart.accepted) begin
                        state <= from_uart.done ? IO_FIN : IO_WAIT;
                    end
                end
                IO_WAIT: if (from_uart.done) state <= IO_FIN;
                default: state <= IO_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            write_r  <= io_type;
            size_r   <= func3[1:0];
            o_data_r <= d_rs1;
        end
        if ((state == IO_REQ || state == IO_WAIT) && from_uart.done && !write_r) begin
            rd <= from_uart.i_data;
        end
    end

    assign to_uart.order      = (state == IO_REQ);
    assign to_uart.write_flag = write_r;
    assign to_uart.size       = size_r;
    assign to_uart.o_data     = o_data_r;

    assign done = (state == IO_FIN);

endmodule

//--- hw/exec.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       order,
    input  exec_info_t exec_info,
    input  logic [`LEN_WORD-1:0] mem_ld,
    input  from_uart_t from_uart,
    output logic       accepted,
    output write_d_r_t write_d_r,
    output j_b_info_t  j_b_info,
    output mem_req_t   mem_req,
    output to_uart_t   to_uart,
    output logic       busy
);

    logic busy_r;
    logic order_able;
    logic done;
    logic is_jump_type;

    logic alu_order, alu_accepted, alu_done;
    logic br_order, br_accepted, br_done, br_taken;
    logic mem_order, mem_accepted, mem_done;
    logic io_order, io_accepted, io_done;
    logic [`LEN_WORD-1:0] alu_rd, br_rd, br_next_pc, mem_rd, io_rd;

    logic                      wr_now, wr_buf, wr_next;
    logic [`LEN_PREG_ADDR-1:0] pa_rd_buf, pa_rd_next;
    logic [`LEN_WORD-1:0]      rd_buf, rd_next;

    assign order_able   = order & ~busy_r;
    assign is_jump_type = (exec_info.exec_type == JUMP);

    // unit select
    assign alu_order = order_able &
        (exec_info.exec_type == ALU || exec_info.exec_type == SUBST);
    assign br_order  = order_able & (is_jump_type || exec_info.exec_type == BRANCH);
    assign mem_order = order_able & (exec_info.exec_type == MEM);
    assign io_order  = order_able & (exec_info.exec_type == IO);

    alu alu_i (
        .clk(clk), .rst_n(rst_n), .order(alu_order),
        .func3(exec_info.func3), .func7(exec_info.func7),
        .subst(exec_info.exec_type == SUBST),
        .d_rs1(exec_info.d_rs1), .d_rs2(exec_info.d_rs2),
        .accepted(alu_accepted), .done(alu_done), .rd(alu_rd)
    );

    branch_unit branch_unit_i (
        .order(br_order), .is_jump(is_jump_type), .func3(exec_info.func3),
        .d_rs1(exec_info.d_rs1), .d_rs2(exec_info.d_rs2),
        .accepted(br_accepted), .done(br_done), .taken(br_taken),
        .next_pc(br_next_pc), .rd(br_rd)
    );

    memory_unit memory_unit_i (
        .clk(clk), .rst_n(rst_n), .order(mem_order),
        .io_type(exec_info.io_type), .func3(exec_info.func3),
        .d_rs1(exec_info.d_rs1), .d_rs2(exec_info.d_rs2), .mem_ld(mem_ld),
        .accepted(mem_accepted), .done(mem_done), .rd(mem_rd), .mem_req(mem_req)
    );

    io_unit io_unit_i (
        .clk(clk), .rst_n(rst_n), .order(io_order),
        .io_type(exec_info.io_type), .func3(exec_info.func3),
        .d_rs1(exec_info.d_rs1), .from_uart(from_uart),
        .accepted(io_accepted), .done(io_done), .rd(io_rd), .to_uart(to_uart)
    );

    assign accepted = alu_accepted | br_accepted | mem_accepted | io_accepted;
    assign done     = alu_done | br_done | mem_done | io_done;

    // busy while an accepted instruction has not finished
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_r <= 1'b0;
            wr_buf <= 1'b0;
        end else begin
            busy_r <= ~done & (busy_r | accepted);
            wr_buf <= wr_next;
        end
    end

    assign busy = busy_r | accepted;

    // stores, branches and uart writes leave the register file alone
    always_comb begin
        case (exec_info.exec_type)
            ALU, SUBST, JUMP: wr_now = 1'b1;
            MEM, IO:          wr_now = ~exec_info.io_type;
            default:          wr_now = 1'b0;
        endcase
    end

    // jump and branch finish in the accept cycle, so look through the buffers
    assign wr_next    = accepted ? wr_now : wr_buf;
    assign pa_rd_next = accepted ? exec_info.pa_rd : pa_rd_buf;

    assign rd_next = alu_done ? alu_rd :
                     br_done  ? br_rd  :
                     mem_done ? mem_rd :
                     io_done  ? io_rd  :
                     rd_buf;

    always_ff @(posedge clk) begin
        pa_rd_buf <= pa_rd_next;
        rd_buf    <= rd_next;
    end

    assign write_d_r.valid = done & wr_next;
    assign write_d_r.pa_rd = pa_rd_next;
    assign write_d_r.data  = rd_next;

    assign j_b_info.is_jump   = br_done & is_jump_type;
    assign j_b_info.next_pc   = br_next_pc;
    assign j_b_info.is_branch = br_done & ~is_jump_type;
    assign j_b_info.ctx       = exec_info.ctx;
    assign j_b_info.hazard    = br_done & ~is_jump_type & br_taken;

endmodule

//--- tb/exec_env.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module mem_model import exec_pkg::*; (
    input  logic                 clk,
    input  mem_req_t             mem_req,
    output logic [`LEN_WORD-1:0] mem_ld
);

    logic [`LEN_WORD-1:0] mem [0:(1<<`LEN_MEM_ADDR)-1];

    // fill pattern built from the whole word address
    initial begin
        for (int i = 0; i < (1 << `LEN_MEM_ADDR); i++) begin
            mem[i] = {i[11:0], 8'ha5, ~i[11:0]};
        end
        mem_ld = '0;
    end

    // read data comes back one cycle after the request
    always @(posedge clk) begin
        if (mem_req.en) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.write[b]) begin
                    mem[mem_req.a][8*b +: 8] <= mem_req.sd[8*b +: 8];
                end
            end
            mem_ld <= mem[mem_req.a];
        end
    end

endmodule

module uart_model import exec_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  to_uart_t             to_uart,
    input  logic [5:0]           acc_delay,
    input  logic [5:0]           done_delay,
    input  logic [`LEN_WORD-1:0] rd_data,
    output from_uart_t           from_uart,
    output to_uart_t             last_req,
    output int                   n_orders
);

    logic       busy_phase;
    logic [5:0] cnt;

    initial begin
        from_uart = '0;
        last_req  = '0;
        n_orders  = 0;
    end

    always @(posedge clk) begin
        from_uart.accepted <= 1'b0;
        from_uart.done     <= 1'b0;
        if (!rst_n) begin
            busy_phase <= 1'b0;
            cnt        <= '0;
        end else if (!busy_phase) begin
            if (to_uart.order) begin
                if (cnt >= acc_delay) begin
                    from_uart.accepted <= 1'b1;
                    last_req   <= to_uart;
                    n_orders   <= n_orders + 1;
                    busy_phase <= 1'b1;
                    cnt        <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end else if (cnt >= done_delay) begin
            from_uart.done   <= 1'b1;
            from_uart.i_data <= rd_data;
            busy_phase <= 1'b0;
            cnt        <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- tb/tb_exec.sv
`timescale 1ns/1ps
`include "exec_cfg.svh"

module tb_exec import exec_pkg::*; ();

    localparam int TMO = 200;

    logic       clk;
    logic       rst_n;
    logic       order;
    exec_info_t exec_info;
    logic       accepted;
    logic       busy;
    write_d_r_t write_d_r;
    j_b_info_t  j_b_info;
    mem_req_t   mem_req;
    to_uart_t   to_uart;
    from_uart_t from_uart;
    to_uart_t   last_req;
    logic [31:0] mem_ld;
    logic [5:0]  acc_delay;
    logic [5:0]  done_delay;
    logic [31:0] uart_data;
    logic [31:0] lfsr;
    logic [31:0] ref_mem [0:4095];
    write_d_r_t last_wr;
    j_b_info_t  last_jb;
    logic       pending;
    int cycle, acc_cyc, last_wr_cyc, last_jb_cyc, n_writes, n_jb, n_orders, held;
    int checks, errors, c0, e0;

    exec dut_i (
        .clk(clk), .rst_n(rst_n), .order(order), .exec_info(exec_info),
        .mem_ld(mem_ld), .from_uart(from_uart), .accepted(accepted),
        .write_d_r(write_d_r), .j_b_info(j_b_info), .mem_req(mem_req),
        .to_uart(to_uart), .busy(busy)
    );

    mem_model mem_i (.clk(clk), .mem_req(mem_req), .mem_ld(mem_ld));

    uart_model uart_i (
        .clk(clk), .rst_n(rst_n), .to_uart(to_uart), .acc_delay(acc_delay),
        .done_delay(done_delay), .rd_data(uart_data), .from_uart(from_uart),
        .last_req(last_req), .n_orders(n_orders)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    assert property (@(posedge clk) disable iff (!rst_n) j_b_info.is_branch |-> !write_d_r.valid)
        else begin
            errors++;
            $display("branch produced a register write");
        end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(accepted && pending)) else begin
                errors++;
                $display("instruction accepted while the previous one was unfinished");
            end
            // a write, a jump or branch report, a store strobe or a finished uart write
            pending = (pending | accepted) &
                      ~(write_d_r.valid | j_b_info.is_jump | j_b_info.is_branch |
                        (|mem_req.write) | (from_uart.done & to_uart.write_flag));
            if (write_d_r.valid) begin
                n_writes++;
                last_wr     = write_d_r;
                last_wr_cyc = cycle;
            end
            if (j_b_info.is_branch || j_b_info.is_jump) begin
                n_jb++;
                last_jb     = j_b_info;
                last_jb_cyc = cycle;
            end
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic exec_info_t mk_info(input exec_type_e t, input logic io,
                                           input logic [2:0] f3, input logic [6:0] f7,
                                           input logic [5:0] pa, input logic [31:0] a,
                                           input logic [31:0] b, input logic [1:0] c);
        exec_info_t e;
        e.exec_type = t;
        e.io_type   = io;
        e.func3     = f3;
        e.func7     = f7;
        e.pa_rd     = pa;
        e.d_rs1     = a;
        e.d_rs2     = b;
        e.ctx       = c;
        return e;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic [6:0] f7,
                                            input logic [31:0] a, input logic [31:0] b);
        alu_op_e op;
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    op = f7[5] ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = f7[5] ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $signed(a) >>> sh;
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic ref_cond(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // only lanes covered by the access size change
    task automatic ref_store(input logic [31:0] addr, input logic [1:0] sz,
                             input logic [31:0] d);
        int n;
        n = (sz == 2'd0) ? 1 : (sz == 2'd1) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            ref_mem[addr[13:2]][8*(addr[1:0]+k) +: 8] = d[8*k +: 8];
        end
    endtask

    function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [2:0] f3);
        logic [31:0] lane;
        lane = ref_mem[addr[13:2]] >> (8 * addr[1:0]);
        case (f3)
            3'd0:    return {{24{lane[7]}}, lane[7:0]};
            3'd1:    return {{16{lane[15]}}, lane[15:0]};
            3'd4:    return {24'd0, lane[7:0]};
            3'd5:    return {16'd0, lane[15:0]};
            default: return lane;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-8s checks %0d errors %0d", name, checks - c0, errors - e0);
        c0 = checks;
        e0 = errors;
    endtask

    // hold order until the DUT takes it
    task automatic issue(input exec_info_t info);
        int i;
        @(posedge clk);
        #10;
        order     = 1'b1;
        exec_info = info;
        for (i = 0; i < TMO; i++) begin
            @(negedge clk);
            if (accepted) break;
            if (busy) held++;
        end
        if (i == TMO) begin
            errors++;
            $display("timeout while waiting for the DUT to accept an instruction");
        end
        acc_cyc = cycle;
        @(posedge clk);
        #10;
        order = 1'b0;
    endtask

    task automatic wait_idle();
        int i;
        for (i = 0; i < TMO; i++) begin
            @(negedge clk);
            if (!busy) break;
        end
        if (i == TMO) begin
            errors++;
            $display("timeout while waiting for busy to drop");
        end
    endtask

    initial begin
        logic [31:0] a, b, r, addr;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [5:0]  pa;
        int nw, nj, no;
        int bf[6];
        int lf[5];
        bf = '{0, 1, 4, 5, 6, 7};
        lf = '{0, 1, 2, 4, 5};
        lfsr = 32'h20b0;
        rst_n = 1'b0;
        order = 1'b0;
        exec_info = '0;
        acc_delay = '0;
        done_delay = '0;
        uart_data = '0;
        pending = 1'b0;
        {cycle, n_writes, n_jb, held, checks, errors, c0, e0} = '0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = {i[11:0], 8'ha5, ~i[11:0]};
        end
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        check("reset outputs", 32'd0, {25'd0, accepted, write_d_r.valid, j_b_info.is_jump,
              j_b_info.is_branch, mem_req.en, to_uart.order, busy});
        end_test("reset");

        repeat (40) begin
            r  = take_bits(3);
            f3 = r[2:0];
            r  = take_bits(1);
            f7 = (r[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            a  = take_bits(32);
            b  = take_bits(32);
            r  = take_bits(6);
            pa = r[5:0];
            r  = take_bits(1);
            nw = n_writes;
            issue(mk_info(r[0] ? SUBST : ALU, 1'b0, f3, f7, pa, a, b, 2'd0));
            wait_idle();
            check("alu writes", nw + 1, n_writes);
            check("alu cycle", acc_cyc + 1, last_wr_cyc);
            check("alu pa_rd", {26'd0, pa}, {26'd0, last_wr.pa_rd});
            check("alu data", r[0] ? a : ref_alu(f3, f7, a, b), last_wr.data);
        end
        end_test("alu");

        for (int j = 0; j < 6; j++) begin
            repeat (6) begin
                a = take_bits(32);
                b = take_bits(32);
                r = take_bits(3);
                if (r[0]) b = a;
                nw = n_writes;
                nj = n_jb;
                issue(mk_info(BRANCH, 1'b0, bf[j][2:0], 7'd0, 6'd9, a, b, r[2:1]));
                wait_idle();
                check("branch reports", nj + 1, n_jb);
                check("branch flag", 32'd1, {31'd0, last_jb.is_branch});
                check("branch cycle", acc_cyc, last_jb_cyc);
                check("branch hazard", {31'd0, ref_cond(bf[j][2:0], a, b)},
                      {31'd0, last_jb.hazard});
                check("branch ctx", {30'd0, r[2:1]}, {30'd0, last_jb.ctx});
                check("branch no write", nw, n_writes);
            end
        end
        repeat (4) begin
            a  = take_bits(32);
            b  = take_bits(32);
            r  = take_bits(6);
            pa = r[5:0];
            issue(mk_info(JUMP, 1'b0, 3'd0, 7'd0, pa, a, b, 2'd0));
            wait_idle();
            check("jump flag", 32'd1, {31'd0, last_jb.is_jump});
            check("jump next_pc", a, last_jb.next_pc);
            check("jump link", b, last_wr.data);
            check("jump cycle", acc_cyc, last_wr_cyc);
        end
        end_test("branch");

        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o += (1 << s)) begin
                addr = (256 + s * 4 + o) * 4 + o;
                b  = take_bits(32);
                nw = n_writes;
                issue(mk_info(MEM, 1'b1, s[2:0], 7'd0, 6'd1, addr, b, 2'd0));
                wait_idle();
                ref_store(addr, s[1:0], b);
                check("store no write", nw, n_writes);
                check("store memory", ref_mem[addr[13:2]], mem_i.mem[addr[13:2]]);
            end
        end
        for (int k = 0; k < 12; k++) begin
            for (int j = 0; j < 5; j++) begin
                for (int o = 0; o < 4; o += (lf[j] % 4 == 0) ? 1 : (lf[j] % 4 == 1) ? 2 : 4) begin
                    addr = (256 + k) * 4 + o;
                    r  = take_bits(6);
                    pa = r[5:0];
                    issue(mk_info(MEM, 1'b0, lf[j][2:0], 7'd0, pa, addr, 32'd0, 2'd0));
                    wait_idle();
                    check("load data", ref_load(addr, lf[j][2:0]), last_wr.data);
                    check("load cycle", acc_cyc + 2, last_wr_cyc);
                    check("load pa_rd", {26'd0, pa}, {26'd0, last_wr.pa_rd});
                end
            end
        end
        end_test("memory");

        repeat (12) begin
            r = take_bits(3);
            a = take_bits(3);
            acc_delay  = a[5:0];
            a = take_bits(3);
            done_delay = a[5:0];
            uart_data  = take_bits(32);
            a  = take_bits(32);
            nw = n_writes;
            no = n_orders;
            issue(mk_info(IO, r[0], {1'b0, r[2:1]}, 7'd0, 6'd5, a, 32'd0, 2'd0));
            wait_idle();
            check("uart orders", no + 1, n_orders);
            check("uart write flag", {31'd0, r[0]}, {31'd0, last_req.write_flag});
            check("uart size", {30'd0, r[2:1]}, {30'd0, last_req.size});
            check("uart o_data", a, last_req.o_data);
            check("uart writes", nw + (r[0] ? 0 : 1), n_writes);
            if (!r[0]) check("uart read data", uart_data, last_wr.data);
        end
        end_test("uart");

        // slow uart keeps the stage busy while an add waits
        acc_delay  = 6'd20;
        done_delay = 6'd15;
        uart_data  = take_bits(32);
        a  = take_bits(32);
        b  = take_bits(32);
        nw = n_writes;
        held = 0;
        issue(mk_info(IO, 1'b0, 3'd2, 7'd0, 6'd7, 32'd0, 32'd0, 2'd0));
        issue(mk_info(ALU, 1'b0, 3'd0, 7'd0, 6'd8, a, b, 2'd0));
        wait_idle();
        check("held while busy", 32'd1, {31'd0, held > 20});
        check("bp writes", nw + 2, n_writes);
        check("bp add data", a + b, last_wr.data);
        check("bp add pa_rd", 32'd8, {26'd0, last_wr.pa_rd});
        end_test("backpress");

        $display("total checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hw
hw/exec_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/memory_unit.sv
hw/io_unit.sv
hw/exec.sv
tb/exec_env.sv
tb/tb_exec.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_exec \
    -Mdir obj_dir

./obj_dir/Vtb_exec > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log
